//--- common/draw_config.svh
`ifndef DRAW_CONFIG_SVH
`define DRAW_CONFIG_SVH

// Visible screen in pixels
`define DRAW_SCREEN_W 640
`define DRAW_SCREEN_H 480

`define DRAW_FB_DEPTH 307200   // W * H cells of 2 bits
`define DRAW_FB_AW    19       // Cell address width

`define DRAW_CMD_DEPTH 4       // Queued draw commands
`define DRAW_PIX_DEPTH 8       // Pixels in flight to the frame store

// AXI4-Lite register map
`define DRAW_REG_WORD_A 32'h0000_0000   // Row, col, colour, shape
`define DRAW_REG_WORD_B 32'h0000_0004   // Size, flags; queues the command
`define DRAW_REG_STATUS 32'h0000_0008   // Busy and done count

`endif

//--- common/draw_pkg.sv
`default_nettype none
`include "draw_config.svh"

package draw_pkg;

    typedef enum logic [1:0] {
        SHAPE_RECT   = 2'b00,
        SHAPE_CIRCLE = 2'b01,
        SHAPE_RSV2   = 2'b10,   // Completes, draws nothing
        SHAPE_RSV3   = 2'b11
    } shape_e;

    typedef struct packed {
        logic [8:0] row;        // Top row or centre row
        logic [9:0] col;        // Left column or centre column
        logic [1:0] color;
        shape_e     shape;
        logic [9:0] size_w;     // Rectangle width
        logic [8:0] size_hr;    // Height or radius
        logic       erase;      // Draw with colour 0
        logic       fill_all;   // Whole screen
    } draw_cmd_t;

    typedef struct packed {
        logic [`DRAW_FB_AW-1:0] addr;   // row * 640 + col
        logic [1:0]             color;
    } pixel_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [31:0] addr;
        logic        valid;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        valid;
    } axil_w_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        valid;
    } axil_ar_t;

    typedef struct packed {
        logic [1:0] resp;
        logic       valid;
    } axil_b_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        valid;
    } axil_r_t;

endpackage

`default_nettype wire

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready,
    output logic     empty
);
    localparam int            PW         = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PW-1:0] LAST_PTR   = PW'(DEPTH - 1);
    localparam logic [PW:0]   COUNT_FULL = (PW + 1)'(DEPTH);

    payload_t      mem [DEPTH];   // Payload storage
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [PW:0]   count_q;       // Occupancy
    logic          push;
    logic          pop;

    assign in_ready  = (count_q != COUNT_FULL);
    assign out_valid = (count_q != '0);
    assign empty     = (count_q == '0);
    assign out_data  = mem[rd_ptr_q];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= in_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;   // Wrap any depth
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (PW + 1)'(push) - (PW + 1)'(pop);
        end
    end

endmodule

`default_nettype wire

//--- cmd_intake/cmd_intake.sv
`timescale 1ns/1ps
`default_nettype none
`include "draw_config.svh"

module cmd_intake (
    input  logic                clk,
    input  logic                rst_n,
    input  draw_pkg::axil_aw_t  aw,
    input  draw_pkg::axil_w_t   w,
    input  draw_pkg::axil_ar_t  ar,
    input  logic                bready,
    input  logic                rready,
    input  logic                cmd_ready,        // Command FIFO has room
    input  logic                raster_busy,
    input  logic                raster_done,      // One pulse per finished command
    input  logic                pix_fifo_empty,
    output logic                awready,
    output logic                wready,
    output logic                arready,
    output draw_pkg::axil_b_t   b,
    output draw_pkg::axil_r_t   r,
    output draw_pkg::draw_cmd_t cmd,
    output logic                cmd_valid
);
    import draw_pkg::*;

    logic        wr_accept_q;   // Shared AW/W ready
    logic        wr_fire;
    logic        rd_fire;
    logic        hit_a;
    logic        hit_b;
    logic [8:0]  row_q;         // Word A fields, kept until the next word A
    logic [9:0]  col_q;
    logic [1:0]  color_q;
    shape_e      shape_q;
    logic [15:0] done_cnt_q;
    logic [3:0]  pending_q;     // Queued but not yet counted
    logic [2:0]  owed_q;        // Done seen, last pixels maybe still queued
    logic        count_en;
    logic        busy;
    logic [31:0] status;

    assign hit_a = (aw.addr == `DRAW_REG_WORD_A);
    assign hit_b = (aw.addr == `DRAW_REG_WORD_B);

    assign awready = wr_accept_q;
    assign wready  = wr_accept_q;
    assign wr_fire = wr_accept_q & aw.valid & w.valid;

    // Ready one cycle after both valids; word B also needs FIFO room
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_accept_q <= 1'b0;
        end else begin
            wr_accept_q <= aw.valid & w.valid & ~wr_accept_q & ~b.valid
                         & (~hit_b | cmd_ready);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q   <= '0;
            col_q   <= '0;
            color_q <= '0;
            shape_q <= SHAPE_RECT;
        end else if (wr_fire && hit_a) begin
            row_q   <= w.data[8:0];
            col_q   <= w.data[18:9];
            color_q <= w.data[20:19];
            shape_q <= shape_e'(w.data[22:21]);
        end
    end

    // Held word A plus the live word B
    always_comb begin
        cmd.row      = row_q;
        cmd.col      = col_q;
        cmd.color    = color_q;
        cmd.shape    = shape_q;
        cmd.size_hr  = w.data[8:0];
        cmd.size_w   = w.data[18:9];
        cmd.erase    = w.data[19];
        cmd.fill_all = w.data[20];
    end

    assign cmd_valid = wr_fire & hit_b;   // Room was checked before ready

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b <= '0;
        end else if (wr_fire) begin
            b.valid <= 1'b1;
            b.resp  <= (hit_a | hit_b) ? RESP_OKAY : RESP_SLVERR;   // Status is read-only
        end else if (bready) begin
            b.valid <= 1'b0;
        end
    end

    assign arready = ~r.valid;            // One read outstanding
    assign rd_fire = ar.valid & arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r <= '0;
        end else if (rd_fire) begin
            r.valid <= 1'b1;
            if (ar.addr == `DRAW_REG_STATUS) begin
                r.data <= status;
                r.resp <= RESP_OKAY;
            end else begin
                r.data <= '0;
                r.resp <= RESP_SLVERR;
            end
        end else if (rready) begin
            r.valid <= 1'b0;
        end
    end

    // Count only once the pixel FIFO has drained into the frame store
    assign count_en = (owed_q != 3'd0) & pix_fifo_empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owed_q     <= '0;
            pending_q  <= '0;
            done_cnt_q <= '0;
        end else begin
            owed_q     <= owed_q + 3'(raster_done) - 3'(count_en);
            pending_q  <= pending_q + 4'(cmd_valid & cmd_ready) - 4'(count_en);
            done_cnt_q <= done_cnt_q + 16'(count_en);
        end
    end

    assign busy   = (pending_q != 4'd0) | raster_busy | ~pix_fifo_empty;
    assign status = {done_cnt_q, 15'd0, busy};

endmodule

`default_nettype wire

//--- raster/shape_raster.sv
`timescale 1ns/1ps
`default_nettype none
`include "draw_config.svh"

module shape_raster (
    input  logic                clk,
    input  logic                rst_n,
    input  draw_pkg::draw_cmd_t cmd,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    output draw_pkg::pixel_t    pix,
    output logic                pix_valid,
    input  logic                pix_ready,
    output logic                busy,
    output logic                done       // One cycle after the last position
);
    import draw_pkg::*;

    localparam int                 AW       = `DRAW_FB_AW;
    localparam logic signed [11:0] X_MAX    = 12'(`DRAW_SCREEN_W - 1);
    localparam logic signed [11:0] Y_MAX    = 12'(`DRAW_SCREEN_H - 1);
    localparam logic [AW-1:0]      ROW_STEP = AW'(`DRAW_SCREEN_W);

    typedef enum logic [1:0] {ST_IDLE, ST_SCAN, ST_DONE} state_e;

    state_e             state_q;
    logic signed [11:0] col_s;                     // Zero-extended command fields
    logic signed [11:0] row_s;
    logic signed [11:0] w_s;
    logic signed [11:0] hr_s;
    logic signed [11:0] bx0;                       // Raw bounding box
    logic signed [11:0] bx1;
    logic signed [11:0] by0;
    logic signed [11:0] by1;
    logic signed [11:0] cx0;                       // Clipped to the screen
    logic signed [11:0] cx1;
    logic signed [11:0] cy0;
    logic signed [11:0] cy1;
    logic               shape_ok;
    logic               box_ok;
    logic [AW-1:0]      start_addr;
    logic [17:0]        r2_next;
    logic [9:0]         x_q;
    logic [9:0]         x0_q;
    logic [9:0]         x1_q;
    logic [9:0]         cx_q;
    logic [8:0]         y_q;
    logic [8:0]         y1_q;
    logic [8:0]         cy_q;
    logic [17:0]        r2_q;
    logic [AW-1:0]      addr_q;                    // Cell at (y_q, x_q)
    logic [AW-1:0]      row_addr_q;                // Cell at (y_q, x0_q)
    logic [1:0]         color_q;
    logic               circle_q;
    logic               fill_q;
    logic               box_ok_q;
    logic signed [24:0] dx;
    logic signed [24:0] dy;
    logic signed [24:0] dist2;
    logic               in_shape;
    logic               last;
    logic               step;

    assign col_s = $signed({2'b00, cmd.col});
    assign row_s = $signed({3'b000, cmd.row});
    assign w_s   = $signed({2'b00, cmd.size_w});
    assign hr_s  = $signed({3'b000, cmd.size_hr});

    always_comb begin
        bx0      = col_s;
        bx1      = col_s;
        by0      = row_s;
        by1      = row_s;
        shape_ok = 1'b1;
        if (cmd.fill_all) begin
            bx0 = 12'sd0;
            bx1 = X_MAX;
            by0 = 12'sd0;
            by1 = Y_MAX;
        end else if (cmd.shape == SHAPE_RECT) begin
            bx1 = col_s + w_s - 12'sd1;    // Zero width gives an empty box
            by1 = row_s + hr_s - 12'sd1;
        end else if (cmd.shape == SHAPE_CIRCLE) begin
            bx0 = col_s - hr_s;
            bx1 = col_s + hr_s;
            by0 = row_s - hr_s;
            by1 = row_s + hr_s;
        end else begin
            shape_ok = 1'b0;               // Reserved codes just complete
        end
        cx0 = (bx0 < 12'sd0) ? 12'sd0 : bx0;
        cx1 = (bx1 > X_MAX) ? X_MAX : bx1;
        cy0 = (by0 < 12'sd0) ? 12'sd0 : by0;
        cy1 = (by1 > Y_MAX) ? Y_MAX : by1;
    end

    assign box_ok     = shape_ok & (cx0 <= cx1) & (cy0 <= cy1);
    assign start_addr = AW'({cy0[8:0], 9'd0}) + AW'({cy0[8:0], 7'd0}) + AW'(cx0[9:0]);   // y*640
    assign r2_next    = {9'd0, cmd.size_hr} * {9'd0, cmd.size_hr};

    // Circle test on the current position
    assign dx       = $signed({15'd0, x_q}) - $signed({15'd0, cx_q});
    assign dy       = $signed({16'd0, y_q}) - $signed({16'd0, cy_q});
    assign dist2    = dx * dx + dy * dy;
    assign in_shape = fill_q | ~circle_q | (dist2 <= $signed({7'd0, r2_q}));

    assign last      = (x_q == x1_q) & (y_q == y1_q);
    assign step      = (state_q == ST_SCAN) & pix_ready;   // Stall while pixel FIFO full
    assign pix_valid = (state_q == ST_SCAN) & box_ok_q & in_shape;
    assign pix.addr  = addr_q;
    assign pix.color = color_q;

    assign cmd_ready = (state_q == ST_IDLE);
    assign busy      = (state_q != ST_IDLE);
    assign done      = (state_q == ST_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: if (cmd_valid) state_q <= ST_SCAN;
                ST_SCAN: if (!box_ok_q || (pix_ready && last)) state_q <= ST_DONE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            x_q        <= cx0[9:0];
            y_q        <= cy0[8:0];
            x0_q       <= cx0[9:0];
            x1_q       <= cx1[9:0];
            y1_q       <= cy1[8:0];
            cx_q       <= cmd.col;
            cy_q       <= cmd.row;
            r2_q       <= r2_next;
            addr_q     <= start_addr;
            row_addr_q <= start_addr;
            color_q    <= cmd.erase ? 2'd0 : cmd.color;
            circle_q   <= (cmd.shape == SHAPE_CIRCLE);
            fill_q     <= cmd.fill_all;
            box_ok_q   <= box_ok;
        end else if (step) begin
            if (x_q == x1_q) begin                 // Next row, back to left edge
                x_q        <= x0_q;
                y_q        <= y_q + 1'b1;
                row_addr_q <= row_addr_q + ROW_STEP;
                addr_q     <= row_addr_q + ROW_STEP;
            end else begin
                x_q    <= x_q + 1'b1;
                addr_q <= addr_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/frame_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "draw_config.svh"

module frame_store (
    input  logic                   clk,
    input  draw_pkg::pixel_t       pix,
    input  logic                   pix_valid,
    input  logic [`DRAW_FB_AW-1:0] rd_addr,
    output logic [1:0]             rd_data
);
    logic [1:0] mem [`DRAW_FB_DEPTH];   // One 2-bit cell per screen pixel

    // Write port, one pixel per cycle, never stalls
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            mem[pix.addr] <= pix.color;
        end
    end

    // Read-back port, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- rtl/draw_engine_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "draw_config.svh"

module draw_engine_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  draw_pkg::axil_aw_t     aw,
    input  draw_pkg::axil_w_t      w,
    input  draw_pkg::axil_ar_t     ar,
    input  logic                   bready,
    input  logic                   rready,
    output logic                   awready,
    output logic                   wready,
    output logic                   arready,
    output draw_pkg::axil_b_t      b,
    output draw_pkg::axil_r_t      r,
    input  logic [`DRAW_FB_AW-1:0] pix_rd_addr,
    output logic [1:0]             pix_rd_data
);
    import draw_pkg::*;

    draw_cmd_t in_cmd;            // Intake to command queue
    logic      in_cmd_valid;
    logic      in_cmd_ready;
    draw_cmd_t q_cmd;             // Command queue to rasterizer
    logic      q_cmd_valid;
    logic      q_cmd_ready;
    pixel_t    r_pix;             // Rasterizer to pixel queue
    logic      r_pix_valid;
    logic      r_pix_ready;
    pixel_t    fs_pix;            // Pixel queue to frame store
    logic      fs_pix_valid;
    logic      pix_empty;
    logic      raster_busy;
    logic      raster_done;

    cmd_intake i_intake (
        .clk            (clk),
        .rst_n          (rst_n),
        .aw             (aw),
        .w              (w),
        .ar             (ar),
        .bready         (bready),
        .rready         (rready),
        .cmd_ready      (in_cmd_ready),
        .raster_busy    (raster_busy),
        .raster_done    (raster_done),
        .pix_fifo_empty (pix_empty),
        .awready        (awready),
        .wready         (wready),
        .arready        (arready),
        .b              (b),
        .r              (r),
        .cmd            (in_cmd),
        .cmd_valid      (in_cmd_valid)
    );

    sync_fifo #(.payload_t(draw_cmd_t), .DEPTH(`DRAW_CMD_DEPTH)) i_cmd_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (in_cmd),
        .in_valid  (in_cmd_valid),
        .in_ready  (in_cmd_ready),
        .out_data  (q_cmd),
        .out_valid (q_cmd_valid),
        .out_ready (q_cmd_ready),
        .empty     ()              // Intake tracks its own pending count
    );

    shape_raster i_raster (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (q_cmd),
        .cmd_valid (q_cmd_valid),
        .cmd_ready (q_cmd_ready),
        .pix       (r_pix),
        .pix_valid (r_pix_valid),
        .pix_ready (r_pix_ready),
        .busy      (raster_busy),
        .done      (raster_done)
    );

    // Frame store takes every pixel, so the queue always pops
    sync_fifo #(.payload_t(pixel_t), .DEPTH(`DRAW_PIX_DEPTH)) i_pix_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (r_pix),
        .in_valid  (r_pix_valid),
        .in_ready  (r_pix_ready),
        .out_data  (fs_pix),
        .out_valid (fs_pix_valid),
        .out_ready (1'b1),
        .empty     (pix_empty)
    );

    frame_store i_fstore (
        .clk       (clk),
        .pix       (fs_pix),
        .pix_valid (fs_pix_valid),
        .rd_addr   (pix_rd_addr),
        .rd_data   (pix_rd_data)
    );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;         // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(negedge clk);      // Four full cycles in reset
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/draw_engine_props.sv
`timescale 1ns/1ps
`default_nettype none
`include "draw_config.svh"

module draw_engine_props (
    input logic                clk,
    input logic                rst_n,
    input draw_pkg::axil_b_t   b,
    input logic                bready,
    input draw_pkg::axil_r_t   r,
    input logic                rready,
    input logic                cmd_valid,
    input logic                cmd_ready,
    input draw_pkg::pixel_t    pix,
    input logic                pix_valid,
    input logic                pix_ready,
    input logic                raster_busy,
    input logic                raster_done
);
    logic active_q;   // Command popped, done not yet seen

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
        end else if (cmd_valid && cmd_ready) begin
            active_q <= 1'b1;
        end else if (raster_done) begin
            active_q <= 1'b0;
        end
    end

    // Write response held until the host takes it
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        b.valid && !bready |=> b.valid && $stable(b.resp))
        else $error("B channel dropped or changed before bready");

    // Read data held until the host takes it
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        r.valid && !rready |=> r.valid && $stable(r.data) && $stable(r.resp))
        else $error("R channel dropped or changed before rready");

    pix_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        pix_valid && pix_ready |-> pix.addr < `DRAW_FB_DEPTH)
        else $error("Pixel pushed outside the frame buffer");

    // Done only for a command taken from the queue
    done_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
        raster_done |-> active_q)
        else $error("Rasterizer done pulse while idle");

    busy_tracks_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        raster_busy == active_q)
        else $error("Rasterizer busy does not match the popped command");

endmodule

bind draw_engine_top draw_engine_props i_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .b           (b),
    .bready      (bready),
    .r           (r),
    .rready      (rready),
    .cmd_valid   (q_cmd_valid),
    .cmd_ready   (q_cmd_ready),
    .pix         (r_pix),
    .pix_valid   (r_pix_valid),
    .pix_ready   (r_pix_ready),
    .raster_busy (raster_busy),
    .raster_done (raster_done)
);

`default_nettype wire

//--- verification/draw_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "draw_config.svh"

module draw_engine_tb;
    import draw_pkg::*;

    localparam int NROWS   = 8;
    localparam int NRANDOM = 8;

    logic                   clk;
    logic                   rst_n;
    axil_aw_t               aw;
    axil_w_t                w;
    axil_ar_t               ar;
    logic                   bready;
    logic                   rready;
    logic                   awready;
    logic                   wready;
    logic                   arready;
    axil_b_t                b;
    axil_r_t                r;
    logic [`DRAW_FB_AW-1:0] pix_rd_addr;
    logic [1:0]             pix_rd_data;

    logic [31:0] tab_a [NROWS];         // Word A per row
    logic [31:0] tab_b [NROWS];         // Word B per row
    logic        tab_skip_a [NROWS];    // Row sends word B only
    int          tab_probe [NROWS][3];  // Cells read back after the row
    int          cycles = 0;
    int          cycle_limit;
    int          seed;

    tb_clock_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    draw_engine_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .aw          (aw),
        .w           (w),
        .ar          (ar),
        .bready      (bready),
        .rready      (rready),
        .awready     (awready),
        .wready      (wready),
        .arready     (arready),
        .b           (b),
        .r           (r),
        .pix_rd_addr (pix_rd_addr),
        .pix_rd_data (pix_rd_data)
    );

    function automatic logic [31:0] word_a(int row, int col, int color, int shape);
        return (32'(shape) << 21) | (32'(color) << 19) | (32'(col) << 9) | 32'(row);
    endfunction

    function automatic logic [31:0] word_b(int hr, int wd, bit erase, bit fill);
        return (32'(fill) << 20) | (32'(erase) << 19) | (32'(wd) << 9) | 32'(hr);
    endfunction

    function automatic int cell_addr(int row, int col);
        return row * `DRAW_SCREEN_W + col;
    endfunction

    // True when the command wa/wb writes this cell; off-screen cells never appear
    function automatic bit covers(logic [31:0] wa, logic [31:0] wb, int addr);
        int row;
        int col;
        int pr;
        int pc;
        int hr;
        int wd;
        row = int'(wa[8:0]);
        col = int'(wa[18:9]);
        hr  = int'(wb[8:0]);
        wd  = int'(wb[18:9]);
        pr  = addr / `DRAW_SCREEN_W;
        pc  = addr % `DRAW_SCREEN_W;
        if (wb[20]) return 1'b1;
        if (wa[22:21] == 2'b00) begin
            return (pc >= col) && (pc < col + wd) && (pr >= row) && (pr < row + hr);
        end
        if (wa[22:21] == 2'b01) begin
            return (pc - col) * (pc - col) + (pr - row) * (pr - row) <= hr * hr;
        end
        return 1'b0;                    // Reserved shape
    endfunction

    // Colour of a cell after rows 0 .. last_row, in table order
    function automatic logic [1:0] expected_color(int addr, int last_row);
        logic [31:0] held;
        logic [1:0]  color;
        held  = '0;                     // Word A fields after reset
        color = 2'd0;
        for (int i = 0; i <= last_row; i++) begin
            if (!tab_skip_a[i]) held = tab_a[i];
            if (covers(held, tab_b[i], addr)) color = tab_b[i][19] ? 2'd0 : held[20:19];
        end
        return color;
    endfunction

    function automatic int box_area(logic [31:0] wa, logic [31:0] wb);
        int hr;
        hr = int'(wb[8:0]);
        if (wb[20]) return `DRAW_FB_DEPTH;
        if (wa[22:21] == 2'b00) return int'(wb[18:9]) * hr;
        if (wa[22:21] == 2'b01) return (2 * hr + 1) * (2 * hr + 1);
        return 0;
    endfunction

    task automatic set_row(int i, bit skip_a, logic [31:0] wa, logic [31:0] wb,
                           int p0, int p1, int p2);
        tab_skip_a[i]   = skip_a;
        tab_a[i]        = wa;
        tab_b[i]        = wb;
        tab_probe[i][0] = p0;
        tab_probe[i][1] = p1;
        tab_probe[i][2] = p2;
    endtask

    task automatic load_table();
        set_row(0, 0, word_a(0, 0, 2, 0), word_b(0, 0, 0, 1),           // Fill colour 2
                cell_addr(0, 0), cell_addr(479, 639), cell_addr(240, 320));
        set_row(1, 0, word_a(10, 20, 1, 0), word_b(5, 8, 0, 0),         // Rect 8x5
                cell_addr(12, 25), cell_addr(10, 28), cell_addr(15, 20));
        set_row(2, 0, word_a(100, 200, 3, 1), word_b(10, 0, 0, 0),      // Circle r 10
                cell_addr(100, 200), cell_addr(100, 210), cell_addr(90, 190));
        set_row(3, 0, word_a(10, 20, 3, 0), word_b(2, 4, 1, 0),         // Erase part of rect
                cell_addr(10, 20), cell_addr(11, 23), cell_addr(12, 23));
        set_row(4, 0, word_a(470, 635, 1, 0), word_b(20, 10, 0, 0),     // Off the corner
                cell_addr(475, 639), cell_addr(476, 0), cell_addr(479, 635));
        set_row(5, 0, word_a(0, 0, 3, 2), word_b(50, 50, 0, 0),         // Reserved code
                cell_addr(0, 0), cell_addr(5, 5), cell_addr(25, 25));
        set_row(6, 0, word_a(2, 3, 1, 1), word_b(5, 0, 0, 0),           // Circle clipped at 0
                cell_addr(0, 0), cell_addr(2, 8), cell_addr(7, 8));
        set_row(7, 1, 32'd0, word_b(2, 0, 1, 0),                        // Word B only, erase
                cell_addr(2, 3), cell_addr(2, 5), cell_addr(2, 6));
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [1:0] exp_resp);
        @(negedge clk);
        aw.addr  = addr;
        aw.valid = 1'b1;
        w.data   = data;
        w.strb   = 4'hf;
        w.valid  = 1'b1;
        bready   = 1'b0;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(negedge clk);                 // AW and W taken on the last edge
        aw.valid = 1'b0;
        w.valid  = 1'b0;
        while (!b.valid) @(negedge clk);
        @(negedge clk);                 // Response must wait for bready
        check("bvalid", 32'(b.valid), 32'd1);
        check($sformatf("bresp@0x%0h", addr), 32'(b.resp), 32'(exp_resp));
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge clk);
        ar.addr  = addr;
        ar.valid = 1'b1;
        rready   = 1'b0;
        while (!arready) @(negedge clk);
        @(negedge clk);
        ar.valid = 1'b0;
        while (!r.valid) @(negedge clk);
        @(negedge clk);                 // Read data must wait for rready
        check("rvalid", 32'(r.valid), 32'd1);
        data   = r.data;
        resp   = r.resp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // Poll status until the engine is idle; returns the last status word
    task automatic wait_idle(output logic [31:0] status);
        logic [1:0] resp;
        status = 32'h1;
        while (status[0]) begin
            axi_read(`DRAW_REG_STATUS, status, resp);
            check("rresp status", 32'(resp), 32'(RESP_OKAY));
        end
    endtask

    task automatic probe_cell(input int addr, input int last_row);
        @(negedge clk);
        pix_rd_addr = `DRAW_FB_AW'(addr);
        @(negedge clk);                 // Registered read
        check($sformatf("pix_rd_data[%0d]", addr), 32'(pix_rd_data),
              32'(expected_color(addr, last_row)));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the engine did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "Run ended by the cycle limit");
        end
    end

    initial begin
        logic [31:0] held;
        logic [31:0] data;
        logic [31:0] rnd;
        logic [1:0]  resp;

        aw          = '0;
        w           = '0;
        ar          = '0;
        bready      = 1'b0;
        rready      = 1'b0;
        pix_rd_addr = '0;
        seed        = 32'h9a25_cc3b;
        load_table();

        held        = '0;
        cycle_limit = 1000;             // Reset, register checks and random probes
        for (int i = 0; i < NROWS; i++) begin
            if (!tab_skip_a[i]) held = tab_a[i];
            cycle_limit += box_area(held, tab_b[i]) + 200;
        end

        wait (rst_n === 1'b1);
        for (int i = 0; i < NROWS; i++) begin
            if (!tab_skip_a[i]) axi_write(`DRAW_REG_WORD_A, tab_a[i], RESP_OKAY);
            axi_write(`DRAW_REG_WORD_B, tab_b[i], RESP_OKAY);
            wait_idle(data);
            check("status.count", 32'(data[31:16]), 32'(i + 1));
            for (int p = 0; p < 3; p++) begin
                probe_cell(tab_probe[i][p], i);
            end
        end

        for (int k = 0; k < NRANDOM; k++) begin
            rnd = $random(seed);
            probe_cell(int'(rnd % 32'(`DRAW_FB_DEPTH)), NROWS - 1);
        end

        // Register map errors; none of them may queue a command
        axi_write(`DRAW_REG_STATUS, 32'hffff_ffff, RESP_SLVERR);
        axi_write(32'h0000_000c, word_b(0, 0, 0, 1), RESP_SLVERR);
        axi_read(32'h0000_0004, data, resp);
        check("rresp@0x4", 32'(resp), 32'(RESP_SLVERR));
        check("rdata@0x4", data, 32'd0);
        wait_idle(data);
        check("status.count", 32'(data[31:16]), 32'(NROWS));
        probe_cell(cell_addr(0, 0), NROWS - 1);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- draw_engine_top.f
+incdir+common
common/draw_pkg.sv
rtl/sync_fifo.sv
cmd_intake/cmd_intake.sv
raster/shape_raster.sv
rtl/frame_store.sv
rtl/draw_engine_top.sv
verification/tb_clock_gen.sv
verification/draw_engine_props.sv
verification/draw_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the simulation with Verilator and run it from the project root
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal \
        --top-module draw_engine_tb \
        -f draw_engine_top.f \
        -o draw_engine_sim &&
    ./obj_dir/draw_engine_sim | tee /dev/stderr | grep -qx "Test passed" ||
    { echo "Simulation did not pass"; exit 1; }
